/* build.f */
hdl/operand_pkg.sv
hdl/operand_fetch.sv
hdl/fetch_join.sv
hdl/operand_fetch_unit.sv
test/tb_mem_model.sv
test/tb_operand_fetch_unit.sv

/* hdl/fetch_join.sv */
`timescale 1ns/1ns

module fetch_join import operand_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  req,
  output logic  ack,
  input  logic  s1_read_q,
  input  logic  s1_write_q,
  input  data_t s1_addr,
  input  data_t s1_wdata,
  output logic  s1_read_dn,
  output logic  s1_write_dn,
  input  logic  s1_done,
  input  logic  s0_read_q,
  input  logic  s0_write_q,
  input  data_t s0_addr,
  input  data_t s0_wdata,
  output logic  s0_read_dn,
  output logic  s0_write_dn,
  input  logic  s0_done,
  output logic  read_q,
  output logic  write_q,
  output data_t addr,
  output data_t wdata,
  input  logic  read_dn,
  input  logic  write_dn
);

  // bus held by one fetcher
  logic busy;
  // 0 means src1 owns the bus, 1 means src0
  logic owner_s0;

  logic s1_req;
  logic s0_req;
  logic owner_read_q;
  logic owner_write_q;

  assign s1_req = s1_read_q || s1_write_q;
  assign s0_req = s0_read_q || s0_write_q;

  // owner's request lines
  assign owner_read_q  = owner_s0 ? s0_read_q : s1_read_q;
  assign owner_write_q = owner_s0 ? s0_write_q : s1_write_q;

  // memory port side
  assign read_q  = busy && owner_read_q;
  assign write_q = busy && owner_write_q;
  assign addr    = owner_s0 ? s0_addr : s1_addr;
  assign wdata   = owner_s0 ? s0_wdata : s1_wdata;

  // done lines go back to the owner only
  assign s1_read_dn  = busy && !owner_s0 && read_dn;
  assign s1_write_dn = busy && !owner_s0 && write_dn;
  assign s0_read_dn  = busy && owner_s0 && read_dn;
  assign s0_write_dn = busy && owner_s0 && write_dn;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      owner_s0 <= 1'b0;
      ack      <= 1'b0;
    end else begin
      // both operands valid, drops once req is seen low
      ack <= req && s1_done && s0_done;
      if (!busy) begin
        // free bus, src1 first
        if (s1_req) begin
          busy     <= 1'b1;
          owner_s0 <= 1'b0;
        end else if (s0_req) begin
          busy     <= 1'b1;
          owner_s0 <= 1'b1;
        end
      end else if (!owner_read_q && !owner_write_q && !read_dn && !write_dn) begin
        // four-phase cycle closed, let the next one in
        busy <= 1'b0;
      end
    end
  end

endmodule

/* hdl/operand_fetch.sv */
`timescale 1ns/1ns

module operand_fetch import operand_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     req,
  input  reg_num_t reg_num,
  input  logic     is_ptr,
  input  step_e    step,
  input  data_t    base_addr,
  output logic     fetch_read_q,
  output logic     fetch_write_q,
  output data_t    fetch_addr,
  output data_t    fetch_wdata,
  input  logic     fetch_read_dn,
  input  logic     fetch_write_dn,
  input  data_t    fetch_rdata,
  output data_t    operand,
  output logic     done
);

  fetch_state_e state;

  // memory location of the register itself
  data_t reg_addr;
  // register word as read from memory
  data_t reg_word;
  // register word after inc or dec
  data_t stepped_word;
  logic  do_step;

  // handshake phases seen from this side of the bus
  logic read_ack;
  logic read_over;
  logic write_ack;
  logic write_over;

  // base_addr and reg_num are stable for the whole request
  assign reg_addr = base_addr + data_t'(reg_num);

  // only 01 and 10 touch the register
  assign do_step = (step == step_inc) || (step == step_dec);
  assign stepped_word = (step == step_dec) ? reg_word - data_t'(1)
                                           : reg_word + data_t'(1);

  // done seen while our request is still up
  assign read_ack  = fetch_read_q && fetch_read_dn;
  assign write_ack = fetch_write_q && fetch_write_dn;
  // request dropped and done fallen again
  assign read_over  = !fetch_read_q && !fetch_read_dn;
  assign write_over = !fetch_write_q && !fetch_write_dn;

  // control part, sequencer and bus requests
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= st_idle;
      fetch_read_q  <= 1'b0;
      fetch_write_q <= 1'b0;
      done          <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          // first read goes out together with the state change
          if (req) begin
            state        <= st_read_reg;
            fetch_read_q <= 1'b1;
          end
        end
        st_read_reg: begin
          if (read_ack) begin
            fetch_read_q <= 1'b0;
          end else if (read_over) begin
            if (is_ptr) begin
              // register holds an address, follow it
              state        <= st_read_ptr;
              fetch_read_q <= 1'b1;
            end else if (do_step) begin
              state         <= st_write_back;
              fetch_write_q <= 1'b1;
            end else begin
              state <= st_done;
              done  <= 1'b1;
            end
          end
        end
        st_read_ptr: begin
          if (read_ack) begin
            fetch_read_q <= 1'b0;
          end else if (read_over) begin
            if (do_step) begin
              state         <= st_write_back;
              fetch_write_q <= 1'b1;
            end else begin
              state <= st_done;
              done  <= 1'b1;
            end
          end
        end
        st_write_back: begin
          if (write_ack) begin
            fetch_write_q <= 1'b0;
          end else if (write_over) begin
            state <= st_done;
            done  <= 1'b1;
          end
        end
        st_done: begin
          // hold the operand until the request goes away
          if (!req) begin
            state <= st_idle;
            done  <= 1'b0;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // data part, addresses and captured words
  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        fetch_addr <= reg_addr;
      end
      st_read_reg: begin
        if (read_ack) begin
          reg_word <= fetch_rdata;
        end else if (read_over) begin
          // direct operand is the register word
          operand     <= reg_word;
          fetch_wdata <= stepped_word;
          fetch_addr  <= is_ptr ? reg_word : reg_addr;
        end
      end
      st_read_ptr: begin
        if (read_ack) begin
          operand <= fetch_rdata;
        end else if (read_over) begin
          // write-back goes to the register, not the pointee
          fetch_addr <= reg_addr;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

/* hdl/operand_fetch_unit.sv */
`timescale 1ns/1ns

module operand_fetch_unit import operand_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  req,
  output logic  ack,
  input  data_t command_word,
  input  data_t base_addr,
  output data_t src1,
  output data_t src0,
  output logic  read_q,
  output logic  write_q,
  output data_t addr,
  output data_t wdata,
  input  data_t rdata,
  input  logic  read_dn,
  input  logic  write_dn
);

  // command word fields
  reg_num_t src1_reg_num;
  reg_num_t src0_reg_num;
  logic     src1_is_ptr;
  logic     src0_is_ptr;
  step_e    src1_step;
  step_e    src0_step;

  // private bus, src1 fetcher
  logic  s1_read_q;
  logic  s1_write_q;
  data_t s1_addr;
  data_t s1_wdata;
  logic  s1_read_dn;
  logic  s1_write_dn;
  logic  s1_done;

  // private bus, src0 fetcher
  logic  s0_read_q;
  logic  s0_write_q;
  data_t s0_addr;
  data_t s0_wdata;
  logic  s0_read_dn;
  logic  s0_write_dn;
  logic  s0_done;

  assign src1_reg_num = command_word[src1_reg_lsb +: reg_num_width];
  assign src0_reg_num = command_word[src0_reg_lsb +: reg_num_width];
  assign src1_is_ptr  = command_word[src1_ptr_bit];
  assign src0_is_ptr  = command_word[src0_ptr_bit];
  assign src1_step    = step_e'(command_word[src1_step_lsb +: step_width]);
  assign src0_step    = step_e'(command_word[src0_step_lsb +: step_width]);

  operand_fetch src1_fetch (
    .clk            (clk),
    .rst            (rst),
    .req            (req),
    .reg_num        (src1_reg_num),
    .is_ptr         (src1_is_ptr),
    .step           (src1_step),
    .base_addr      (base_addr),
    .fetch_read_q   (s1_read_q),
    .fetch_write_q  (s1_write_q),
    .fetch_addr     (s1_addr),
    .fetch_wdata    (s1_wdata),
    .fetch_read_dn  (s1_read_dn),
    .fetch_write_dn (s1_write_dn),
    .fetch_rdata    (rdata),
    .operand        (src1),
    .done           (s1_done)
  );

  operand_fetch src0_fetch (
    .clk            (clk),
    .rst            (rst),
    .req            (req),
    .reg_num        (src0_reg_num),
    .is_ptr         (src0_is_ptr),
    .step           (src0_step),
    .base_addr      (base_addr),
    .fetch_read_q   (s0_read_q),
    .fetch_write_q  (s0_write_q),
    .fetch_addr     (s0_addr),
    .fetch_wdata    (s0_wdata),
    .fetch_read_dn  (s0_read_dn),
    .fetch_write_dn (s0_write_dn),
    .fetch_rdata    (rdata),
    .operand        (src0),
    .done           (s0_done)
  );

  // shares the memory port and raises ack
  fetch_join i_join (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .ack         (ack),
    .s1_read_q   (s1_read_q),
    .s1_write_q  (s1_write_q),
    .s1_addr     (s1_addr),
    .s1_wdata    (s1_wdata),
    .s1_read_dn  (s1_read_dn),
    .s1_write_dn (s1_write_dn),
    .s1_done     (s1_done),
    .s0_read_q   (s0_read_q),
    .s0_write_q  (s0_write_q),
    .s0_addr     (s0_addr),
    .s0_wdata    (s0_wdata),
    .s0_read_dn  (s0_read_dn),
    .s0_write_dn (s0_write_dn),
    .s0_done     (s0_done),
    .read_q      (read_q),
    .write_q     (write_q),
    .addr        (addr),
    .wdata       (wdata),
    .read_dn     (read_dn),
    .write_dn    (write_dn)
  );

endmodule

/* hdl/operand_pkg.sv */
package operand_pkg;

  // word sizes
  localparam int data_width    = 32;
  localparam int reg_num_width = 4;
  localparam int step_width    = 2;

  // one memory word, data or address
  typedef logic [data_width-1:0] data_t;
  // register index inside the register file window
  typedef logic [reg_num_width-1:0] reg_num_t;

  // command word layout, source slots only
  localparam int src1_reg_lsb  = 0;
  localparam int src0_reg_lsb  = 4;
  localparam int src1_ptr_bit  = 16;
  localparam int src0_ptr_bit  = 17;
  localparam int src1_step_lsb = 20;
  localparam int src0_step_lsb = 22;

  // register step after the read
  // step_keep acts like step_none
  typedef enum logic [step_width-1:0] {
    step_none = 2'b00,
    step_inc  = 2'b01,
    step_dec  = 2'b10,
    step_keep = 2'b11
  } step_e;

  // per-slot fetch sequencer
  typedef enum logic [2:0] {
    st_idle,
    st_read_reg,
    st_read_ptr,
    st_write_back,
    st_done
  } fetch_state_e;

endpackage

/* test/tb_mem_model.sv */
`timescale 1ns/1ns

module tb_mem_model import operand_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  read_q,
  input  logic  write_q,
  input  data_t addr,
  input  data_t wdata,
  output data_t rdata,
  output logic  read_dn,
  output logic  write_dn
);

  // word storage, indexed by the low address bits
  data_t mem [0:255];
  // address of every write, in arrival order
  data_t write_log [$];

  // cycles still to wait before answering
  int unsigned wait_left;
  logic        waiting;

  always @(posedge clk) begin
    int unsigned delay;
    logic        ready;
    ready = 1'b0;
    if (rst) begin
      rdata     <= '0;
      read_dn   <= 1'b0;
      write_dn  <= 1'b0;
      waiting   <= 1'b0;
      wait_left <= 0;
    end else if (read_dn || write_dn) begin
      // close the cycle once the request is gone
      if (!read_q && !write_q) begin
        read_dn  <= 1'b0;
        write_dn <= 1'b0;
      end
    end else if (read_q || write_q) begin
      if (!waiting) begin
        // new request, 0 to 3 cycles of latency
        delay = $urandom % 4;
        if (delay == 0) begin
          ready = 1'b1;
        end else begin
          waiting   <= 1'b1;
          wait_left <= delay;
        end
      end else if (wait_left == 1) begin
        ready   = 1'b1;
        waiting <= 1'b0;
      end else begin
        wait_left <= wait_left - 1;
      end
      if (ready) begin
        if (read_q) begin
          rdata   <= mem[addr[7:0]];
          read_dn <= 1'b1;
        end else begin
          mem[addr[7:0]] = wdata;
          write_log.push_back(addr);
          write_dn <= 1'b1;
        end
      end
    end
  end

endmodule

/* test/tb_operand_fetch_unit.sv */
`timescale 1ns/1ns

module tb_operand_fetch_unit import operand_pkg::*; ();

  logic  clk;
  logic  rst;
  logic  req;
  logic  ack;
  data_t command_word;
  data_t base_addr;
  data_t src1;
  data_t src0;
  logic  read_q;
  logic  write_q;
  data_t addr;
  data_t wdata;
  data_t rdata;
  logic  read_dn;
  logic  write_dn;

  // expected memory contents per the fetch rules
  data_t model [0:255];
  data_t exp_src1;
  data_t exp_src0;
  int    exp_writes;

  int unsigned check_count = 0;
  int unsigned value_errors = 0;
  int unsigned protocol_errors = 0;
  int unsigned cycle_count = 0;
  int unsigned requests_issued = 0;

  operand_fetch_unit i_operand_fetch_unit (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .ack          (ack),
    .command_word (command_word),
    .base_addr    (base_addr),
    .src1         (src1),
    .src0         (src0),
    .read_q       (read_q),
    .write_q      (write_q),
    .addr         (addr),
    .wdata        (wdata),
    .rdata        (rdata),
    .read_dn      (read_dn),
    .write_dn     (write_dn)
  );

  tb_mem_model i_mem (
    .clk      (clk),
    .rst      (rst),
    .read_q   (read_q),
    .write_q  (write_q),
    .addr     (addr),
    .wdata    (wdata),
    .rdata    (rdata),
    .read_dn  (read_dn),
    .write_dn (write_dn)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // run limit grows with every request issued
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > 80 * (requests_issued + 1)) begin
      $display("timeout: no ack after %0d cycles, request %0d", cycle_count, requests_issued);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_operand(input data_t got, input data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mem_word(input data_t got, input data_t exp, input int idx);
    check_count++;
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t: mem[%0d] is %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_write_count(input int got, input int exp);
    check_count++;
    if (got != exp) begin
      value_errors++;
      $display("[FAIL] %0t: %0d write-backs, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // distinct word per index from all eight bits
  function automatic data_t mem_pattern(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h3c, idx + 8'h11};
  endfunction

  task automatic load_word(input logic [7:0] idx, input data_t value);
    i_mem.mem[idx] = value;
    model[idx] = value;
  endtask

  task automatic fill_memory(input logic use_random);
    for (int i = 0; i < 256; i++) begin
      load_word(8'(i), use_random ? data_t'($urandom) : mem_pattern(8'(i)));
    end
  endtask

  function automatic data_t make_cmd(input reg_num_t r1, input reg_num_t r0, input logic p1,
                                     input logic p0, input step_e s1, input step_e s0);
    data_t cmd;
    cmd = '0;
    cmd[src1_reg_lsb +: reg_num_width] = r1;
    cmd[src0_reg_lsb +: reg_num_width] = r0;
    cmd[src1_ptr_bit] = p1;
    cmd[src0_ptr_bit] = p0;
    cmd[src1_step_lsb +: step_width] = s1;
    cmd[src0_step_lsb +: step_width] = s0;
    return cmd;
  endfunction

  // operand and register update for one slot
  task automatic predict_slot(input reg_num_t n, input logic ptr, input step_e st,
                              input data_t base, output data_t op);
    logic [7:0] reg_idx;
    data_t      reg_word;
    reg_idx  = base[7:0] + 8'(n);
    reg_word = model[reg_idx];
    op = ptr ? model[reg_word[7:0]] : reg_word;
    if (st == step_inc) begin
      model[reg_idx] = reg_word + 32'd1;
      exp_writes++;
    end else if (st == step_dec) begin
      model[reg_idx] = reg_word - 32'd1;
      exp_writes++;
    end
  endtask

  // one four-phase request with all checks
  // hold is the number of extra cycles req stays up after ack
  task automatic run_and_check(input reg_num_t r1, input reg_num_t r0, input logic p1,
                               input logic p0, input step_e s1, input step_e s0,
                               input data_t base, input int hold);
    exp_writes = 0;
    predict_slot(r1, p1, s1, base, exp_src1);
    predict_slot(r0, p0, s0, base, exp_src0);
    i_mem.write_log.delete();
    @(negedge clk);
    command_word = make_cmd(r1, r0, p1, p0, s1, s0);
    base_addr    = base;
    req          = 1'b1;
    requests_issued++;
    do @(negedge clk); while (!ack);
    check_operand(src1, exp_src1, "src1");
    check_operand(src0, exp_src0, "src0");
    repeat (hold) begin
      @(negedge clk);
      check_flag(ack, 1'b1, "ack while req held");
      check_operand(src1, exp_src1, "src1 while req held");
      check_operand(src0, exp_src0, "src0 while req held");
    end
    for (int i = 0; i < 256; i++) begin
      check_mem_word(i_mem.mem[i], model[i], i);
    end
    check_write_count(i_mem.write_log.size(), exp_writes);
    req = 1'b0;
    // ack drops on the first clock that sees req low
    @(negedge clk);
    if (ack) begin
      protocol_errors++;
      $display("handshake error: ack still high one cycle after req dropped");
    end
  endtask

  task automatic test_reset_idle;
    repeat (2) @(negedge clk);
    check_flag(ack, 1'b0, "ack after reset");
    check_flag(read_q, 1'b0, "read_q after reset");
    check_flag(write_q, 1'b0, "write_q after reset");
  endtask

  task automatic test_direct;
    fill_memory(1'b0);
    run_and_check(4'd3, 4'd9, 1'b0, 1'b0, step_none, step_none, 32'h0000_0040, 0);
  endtask

  task automatic test_indirect;
    fill_memory(1'b0);
    // upper pointer bits fall outside the memory window
    load_word(8'h61, 32'h0000_00a5);
    load_word(8'h6c, 32'h1234_00c3);
    run_and_check(4'd1, 4'd12, 1'b1, 1'b1, step_none, step_none, 32'h0000_0060, 0);
  endtask

  task automatic test_step;
    fill_memory(1'b0);
    run_and_check(4'd2, 4'd5, 1'b0, 1'b0, step_inc, step_dec, 32'h0000_0010, 0);
    load_word(8'h17, 32'h0000_00e0);
    load_word(8'h18, 32'h0000_00f0);
    run_and_check(4'd7, 4'd8, 1'b1, 1'b1, step_inc, step_dec, 32'h0000_0010, 0);
    // wrap at both ends of the word
    load_word(8'h1a, 32'hffff_ffff);
    load_word(8'h1b, 32'h0000_0000);
    run_and_check(4'd10, 4'd11, 1'b0, 1'b0, step_inc, step_dec, 32'h0000_0010, 0);
    run_and_check(4'd2, 4'd5, 1'b0, 1'b1, step_keep, step_keep, 32'h0000_0010, 0);
  endtask

  task automatic test_handshake;
    fill_memory(1'b0);
    run_and_check(4'd0, 4'd15, 1'b0, 1'b0, step_none, step_none, 32'h0000_0030, 6);
    run_and_check(4'd6, 4'd4, 1'b1, 1'b0, step_inc, step_none, 32'h0000_00b0, 0);
  endtask

  task automatic test_random;
    data_t    base;
    reg_num_t r1;
    reg_num_t r0;
    logic     p1;
    logic     p0;
    for (int k = 0; k < 40; k++) begin
      fill_memory(1'b1);
      // register window stays below 32
      base = ($urandom & 32'hffff_ff00) | ($urandom % 16);
      r1 = reg_num_t'($urandom);
      do r0 = reg_num_t'($urandom); while (r0 == r1);
      p1 = 1'($urandom);
      p0 = 1'($urandom);
      // pointers aim above the register window
      if (p1)
        load_word(base[7:0] + 8'(r1), ($urandom & 32'hffff_ff00) | (32 + $urandom % 224));
      if (p0)
        load_word(base[7:0] + 8'(r0), ($urandom & 32'hffff_ff00) | (32 + $urandom % 224));
      run_and_check(r1, r0, p1, p0, step_e'(2'($urandom)), step_e'(2'($urandom)), base,
                    $urandom % 3);
    end
  endtask

  initial begin
    void'($urandom(32'h1268));
    rst          = 1'b1;
    req          = 1'b0;
    command_word = '0;
    base_addr    = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_idle();
    test_direct();
    test_indirect();
    test_step();
    test_handshake();
    test_random();
    repeat (2) @(negedge clk);
    $display("checks %0d, value errors %0d, protocol errors %0d",
             check_count, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
